// ==== dv/csi2_raw10_rx_sva.sv ====
`timescale 1ns/1ps
`default_nettype none

module csi2_raw10_rx_sva
(
  input wire                            clk_i,
  input wire                            srst_i,
  input wire csi2_rx_pkg::stream32_t    pkt_i,
  input wire                            pkt_ready_o,
  input wire csi2_rx_pkg::pix_stream_t  pix_o,
  input wire                            pix_ready_i,
  input wire csi2_rx_pkg::hdr_rpt_t     hdr_o,
  input wire                            len_err_o
);

  int fail_cnt = 0;

  // a stalled group stays put until taken.
  pix_hold_a: assert property ( @( posedge clk_i ) disable iff ( srst_i )
    pix_o.valid && !pix_ready_i |=> pix_o.valid && $stable( pix_o ) )
    else
    begin
      $error( "pix_o changed or dropped while stalled" );
      fail_cnt++;
    end

  pix_rst_a: assert property ( @( posedge clk_i )
    srst_i |=> !pix_o.valid )
    else
    begin
      $error( "pix_o valid high under reset" );
      fail_cnt++;
    end

  // header beats are always separated by payload.
  hdr_pulse_a: assert property ( @( posedge clk_i ) disable iff ( srst_i )
    hdr_o.valid |=> !hdr_o.valid )
    else
    begin
      $error( "hdr_o valid longer than one cycle" );
      fail_cnt++;
    end

  len_err_a: assert property ( @( posedge clk_i ) disable iff ( srst_i )
    len_err_o |-> $past( pkt_i.valid && pkt_ready_o && pkt_i.last ) )
    else
    begin
      $error( "len_err_o without a preceding last beat" );
      fail_cnt++;
    end

endmodule

bind csi2_raw10_rx csi2_raw10_rx_sva i_sva
(
  .clk_i       ( clk_i       ),
  .srst_i      ( srst_i      ),
  .pkt_i       ( pkt_i       ),
  .pkt_ready_o ( pkt_ready_o ),
  .pix_o       ( pix_o       ),
  .pix_ready_i ( pix_ready_i ),
  .hdr_o       ( hdr_o       ),
  .len_err_o   ( len_err_o   )
);

`default_nettype wire

// ==== dv/csi2_raw10_rx_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "csi2_rx_settings.svh"

module csi2_raw10_rx_tb;

  import csi2_rx_pkg::*;

  localparam int WORDS_TOTAL     = 21 + 26 + 34 + 29 + 64 + 22;
  localparam int WATCHDOG_CYCLES = WORDS_TOTAL * 8 + 1000;
  localparam int DRAIN_LIMIT     = 200;
  localparam int ALL_BEATS       = 1 << 16;

  logic        clk_i;
  logic        srst_i;
  stream32_t   pkt_i;
  logic        pkt_ready_o;
  pix_stream_t pix_o;
  logic        pix_ready_i;
  hdr_rpt_t    hdr_o;
  logic        len_err_o;

  logic [31:0] tx_words[$];
  pix_grp_t    exp_pix[$];
  logic        exp_last[$];
  hdr_rpt_t    exp_hdr[$];
  logic        exp_len[$];
  string       test_name;
  int          mismatch_cnt;
  int          other_cnt;
  int          assert_cnt;
  int          seed_draw;
  logic        len_pending;
  logic        bp_en;

  csi2_raw10_rx i_csi2_raw10_rx
  (
    .clk_i       ( clk_i       ),
    .srst_i      ( srst_i      ),
    .pkt_i       ( pkt_i       ),
    .pkt_ready_o ( pkt_ready_o ),
    .pix_o       ( pix_o       ),
    .pix_ready_i ( pix_ready_i ),
    .hdr_o       ( hdr_o       ),
    .len_err_o   ( len_err_o   )
  );

  always #2 clk_i = ~clk_i;  // 4 ns period.

  always @( negedge clk_i )
    pix_ready_i = bp_en ? 1'( $urandom_range( 1, 0 ) ) : 1'b1;  // random stall.

  task automatic note_failure( input string what );
    other_cnt++;
    $display( "%s: %s", test_name, what );
  endtask

  task automatic check_pix( input pix_grp_t exp_g, input logic exp_l, input pix_stream_t act );
    if ( act.pix !== exp_g || act.last !== exp_l )
    begin
      mismatch_cnt++;
      $display( "Mismatch %s: pixels exp %h last %b, got %h last %b",
                test_name, exp_g, exp_l, act.pix, act.last );
    end
  endtask

  task automatic check_hdr( input hdr_rpt_t exp_h, input hdr_rpt_t act );
    if ( { act.vc, act.dt, act.wc } !== { exp_h.vc, exp_h.dt, exp_h.wc } )
    begin
      mismatch_cnt++;
      $display( "Mismatch %s: header exp vc %0d dt %h wc %0d, got vc %0d dt %h wc %0d",
                test_name, exp_h.vc, exp_h.dt, exp_h.wc, act.vc, act.dt, act.wc );
    end
  endtask

  task automatic check_len_err( input logic exp_e, input logic act_e );
    if ( act_e !== exp_e )
    begin
      mismatch_cnt++;
      $display( "Mismatch %s: len_err exp %b, got %b", test_name, exp_e, act_e );
    end
  endtask

  // transfers seen at the rising edge, before any register update.
  always @( posedge clk_i )
  begin
    if ( srst_i )
      len_pending = 1'b0;
    else
    begin
      if ( pix_o.valid && pix_ready_i )
      begin
        if ( exp_pix.size() == 0 )
          note_failure( "pixel group appeared with none expected" );
        else
          check_pix( exp_pix.pop_front(), exp_last.pop_front(), pix_o );
      end
      if ( hdr_o.valid )
      begin
        if ( exp_hdr.size() == 0 )
          note_failure( "header strobe appeared with none expected" );
        else
          check_hdr( exp_hdr.pop_front(), hdr_o );
      end
      if ( len_pending )
      begin
        if ( exp_len.size() == 0 )
          note_failure( "packet ended with no length result expected" );
        else
          check_len_err( exp_len.pop_front(), len_err_o );
      end
      else if ( len_err_o )
        note_failure( "len_err_o pulsed outside a packet end" );
      len_pending = pkt_i.valid && pkt_ready_o && pkt_i.last;
    end
  end

  task automatic put_header( input logic [5:0] dt, input logic [1:0] vc, input int n_bytes,
                             input int wc_delta );
    csi2_word_u h;
    hdr_rpt_t   r;
    h.hdr.ecc = 8'($urandom);
    h.hdr.wc  = 16'( n_bytes + wc_delta );
    h.hdr.vc  = vc;
    h.hdr.dt  = dt;
    tx_words.push_back( h );
    r = '{vc: vc, dt: dt, wc: h.hdr.wc, valid: 1'b1};
    exp_hdr.push_back( r );
    exp_len.push_back( wc_delta != 0 );
  endtask

  task automatic build_raw10_line( input logic [1:0] vc, input int n_pix, input int wc_delta );
    logic [7:0] b[$];
    logic [9:0] p;
    logic [7:0] lsb;
    pix_grp_t   g;
    for ( int i = 0; i < n_pix / 4; i++ )
    begin
      lsb = '0;
      for ( int k = 0; k < 4; k++ )
      begin
        p = 10'($urandom);
        g[k] = p;
        b.push_back( p[9:2] );
        lsb[2*k +: 2] = p[1:0];  // pixel k low bits.
      end
      b.push_back( lsb );
      exp_pix.push_back( g );
      exp_last.push_back( i == n_pix / 4 - 1 );
    end
    put_header( `CSI2_DT_RAW10, vc, b.size(), wc_delta );
    for ( int i = 0; i < b.size() / 4; i++ )
      tx_words.push_back( { b[4*i+3], b[4*i+2], b[4*i+1], b[4*i] } );  // byte 0 first.
  endtask

  task automatic build_other_packet( input logic [5:0] dt, input logic [1:0] vc,
                                     input int n_words, input int wc_delta );
    put_header( dt, vc, 4 * n_words, wc_delta );
    repeat ( n_words )
      tx_words.push_back( $urandom );
  endtask

  task automatic drive_beat( input logic [31:0] data, input logic last, input bit gaps );
    @( negedge clk_i );
    while ( gaps && $urandom_range( 2, 0 ) == 0 )
    begin
      pkt_i.valid = 1'b0;
      @( negedge clk_i );
    end
    pkt_i.data  = data;
    pkt_i.last  = last;
    pkt_i.valid = 1'b1;
    @( posedge clk_i );
    while ( !pkt_ready_o )
      @( posedge clk_i );
  endtask

  task automatic send_packet( input bit gaps, input int max_beats );
    int          sent;
    logic [31:0] w;
    sent = 0;
    while ( tx_words.size() != 0 && sent < max_beats )
    begin
      w = tx_words.pop_front();
      drive_beat( w, tx_words.size() == 0, gaps );
      sent++;
    end
    @( negedge clk_i );
    pkt_i.valid = 1'b0;
  endtask

  task automatic wait_drain();
    int n;
    n = 0;
    while ( ( exp_pix.size() + exp_hdr.size() + exp_len.size() ) != 0 && n < DRAIN_LIMIT )
    begin
      @( negedge clk_i );
      n++;
    end
    if ( ( exp_pix.size() + exp_hdr.size() + exp_len.size() ) != 0 )
      note_failure( $sformatf( "%0d pixel groups, %0d headers, %0d length results missing",
                               exp_pix.size(), exp_hdr.size(), exp_len.size() ) );
    repeat ( 8 ) @( negedge clk_i );  // room for extra outputs.
  endtask

  task automatic apply_reset( input int cycles );
    @( negedge clk_i );
    pkt_i  = '0;
    srst_i = 1'b1;
    tx_words.delete();
    exp_pix.delete();
    exp_last.delete();
    exp_hdr.delete();
    exp_len.delete();
    repeat ( cycles ) @( negedge clk_i );
    srst_i = 1'b0;
  endtask

  task automatic line_ready_high();
    test_name = "raw10 line";
    build_raw10_line( 2'd0, 64, 0 );
    send_packet( 1'b0, ALL_BEATS );
    wait_drain();
  endtask

  task automatic header_report();
    test_name = "header report";
    build_raw10_line( 2'd1, 32, 0 );
    send_packet( 1'b0, ALL_BEATS );
    build_other_packet( 6'h2A, 2'd3, 8, 0 );  // RAW8.
    send_packet( 1'b0, ALL_BEATS );
    build_raw10_line( 2'd2, 16, 0 );
    send_packet( 1'b0, ALL_BEATS );
    wait_drain();
  endtask

  task automatic dt_filter();
    test_name = "data type filter";
    build_other_packet( 6'h2A, 2'd0, 12, 0 );
    send_packet( 1'b0, ALL_BEATS );
    build_raw10_line( 2'd0, 64, 0 );
    send_packet( 1'b0, ALL_BEATS );
    wait_drain();
  endtask

  task automatic length_check();
    test_name = "length check";
    build_raw10_line( 2'd0, 32, 4 );  // word count too large.
    send_packet( 1'b0, ALL_BEATS );
    build_raw10_line( 2'd1, 32, 0 );
    send_packet( 1'b0, ALL_BEATS );
    build_other_packet( 6'h12, 2'd2, 6, -4 );
    send_packet( 1'b0, ALL_BEATS );
    wait_drain();
  endtask

  task automatic back_pressure();
    test_name = "back pressure";
    bp_en = 1'b1;
    repeat ( 4 )
    begin
      build_raw10_line( 2'($urandom), 48, 0 );
      send_packet( 1'b1, ALL_BEATS );
    end
    wait_drain();
    bp_en = 1'b0;
  endtask

  task automatic reset_recovery();
    test_name = "reset recovery";
    build_raw10_line( 2'd0, 32, 0 );
    send_packet( 1'b0, 6 );  // cut off mid packet.
    apply_reset( 4 );
    @( negedge clk_i );
    if ( pix_o.valid || hdr_o.valid || len_err_o || !pkt_ready_o )
      note_failure( "outputs not idle after reset" );
    build_raw10_line( 2'd1, 32, 0 );
    send_packet( 1'b0, ALL_BEATS );
    wait_drain();
  endtask

  initial
  begin
    seed_draw    = $urandom( 32'h8bd1 );
    clk_i        = 1'b0;
    srst_i       = 1'b1;
    pkt_i        = '0;
    pix_ready_i  = 1'b1;
    bp_en        = 1'b0;
    len_pending  = 1'b0;
    mismatch_cnt = 0;
    other_cnt    = 0;
    assert_cnt   = 0;
    test_name    = "power-on reset";
    apply_reset( 16 );
    line_ready_high();
    header_report();
    dt_filter();
    length_check();
    back_pressure();
    reset_recovery();
    assert_cnt = i_csi2_raw10_rx.i_sva.fail_cnt;
    $display( "errors: %0d mismatches, %0d other failures, %0d assertion failures",
              mismatch_cnt, other_cnt, assert_cnt );
    if ( mismatch_cnt + other_cnt + assert_cnt == 0 )
      $display( "TESTBENCH PASSED" );
    else
      $display( "TESTBENCH FAILED" );
    $finish;
  end

  initial
  begin
    repeat ( WATCHDOG_CYCLES ) @( posedge clk_i );
    $display( "watchdog: run took more than %0d cycles in %s", WATCHDOG_CYCLES, test_name );
    $display( "TESTBENCH FAILED" );
    $finish;
  end

endmodule

`default_nettype wire

// ==== list.f ====
+incdir+verilog
verilog/csi2_rx_pkg.sv
verilog/csi2_pkt_hdr_parser.sv
verilog/csi2_raw10_32b_40b_gbx.sv
verilog/csi2_raw10_unpacker.sv
verilog/csi2_raw10_rx.sv
dv/csi2_raw10_rx_sva.sv
dv/csi2_raw10_rx_tb.sv

// ==== verilog/csi2_pkt_hdr_parser.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "csi2_rx_settings.svh"

module csi2_pkt_hdr_parser
(
  input  wire                            clk_i,
  input  wire                            srst_i,
  input  wire csi2_rx_pkg::stream32_t    pkt_i,
  output logic                           pkt_ready_o,
  output csi2_rx_pkg::stream32_t         pay_o,
  input  wire                            pay_ready_i,
  output csi2_rx_pkg::hdr_rpt_t          hdr_o,
  output logic                           len_err_o
);

  import csi2_rx_pkg::*;

  typedef enum logic [1:0]
  {
    ST_HDR,
    ST_PASS,
    ST_DROP
  } state_t;

  state_t      state;
  state_t      next_state;
  csi2_word_u  in_w;
  logic        is_raw10;
  logic        in_xfer;
  logic        hdr_xfer;
  logic        pay_xfer;
  logic        pass_xfer;
  logic [15:0] byte_cnt;
  logic [15:0] byte_cnt_nxt;

  assign in_w     = pkt_i.data;
  assign is_raw10 = ( in_w.hdr.dt == `CSI2_DT_RAW10 );

  // only forwarded payload waits on the gearbox.
  assign pkt_ready_o = ( state == ST_PASS ) ? pay_ready_i : 1'b1;

  assign in_xfer   = pkt_i.valid && pkt_ready_o;
  assign hdr_xfer  = in_xfer && ( state == ST_HDR );
  assign pay_xfer  = in_xfer && ( state != ST_HDR );
  assign pass_xfer = in_xfer && ( state == ST_PASS );

  always_comb
  begin
    next_state = state;
    case ( state )
      ST_HDR:
      begin
        if ( hdr_xfer )
          next_state = is_raw10 ? ST_PASS : ST_DROP;
      end
      ST_PASS, ST_DROP:
      begin
        if ( pay_xfer && pkt_i.last )
          next_state = ST_HDR;
      end
      default:
      begin
        next_state = ST_HDR;
      end
    endcase
  end

  always_ff @( posedge clk_i )
    if ( srst_i )
      state <= ST_HDR;
    else
      state <= next_state;

  assign byte_cnt_nxt = byte_cnt + 16'd4;  // four bytes per beat.

  always_ff @( posedge clk_i )
    if ( srst_i )
      byte_cnt <= '0;
    else if ( hdr_xfer )
      byte_cnt <= '0;
    else if ( pay_xfer )
      byte_cnt <= byte_cnt_nxt;

  // hdr_o.wc holds the word count of the packet in flight.
  always_ff @( posedge clk_i )
    if ( srst_i )
      len_err_o <= 1'b0;
    else
      len_err_o <= pay_xfer && pkt_i.last && ( byte_cnt_nxt != hdr_o.wc );

  always_ff @( posedge clk_i )
    if ( srst_i )
      hdr_o.valid <= 1'b0;
    else
    begin
      hdr_o.valid <= hdr_xfer;
      if ( hdr_xfer )
      begin
        hdr_o.vc <= in_w.hdr.vc;
        hdr_o.dt <= in_w.hdr.dt;
        hdr_o.wc <= in_w.hdr.wc;
      end
    end

  always_ff @( posedge clk_i )
    if ( srst_i )
      pay_o.valid <= 1'b0;
    else if ( pass_xfer )
      pay_o <= pkt_i;
    else if ( pay_ready_i )
      pay_o.valid <= 1'b0;

endmodule

`default_nettype wire

// ==== verilog/csi2_raw10_32b_40b_gbx.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "csi2_rx_settings.svh"

module csi2_raw10_32b_40b_gbx
(
  input  wire                            clk_i,
  input  wire                            srst_i,
  input  wire csi2_rx_pkg::stream32_t    pkt_i,
  output logic                           pkt_ready_o,
  output csi2_rx_pkg::stream40_t         pkt_o,
  input  wire                            pkt_ready_i
);

  import csi2_rx_pkg::*;

  typedef enum logic [2:0]
  {
    FIRST_S,
    SECOND_S,
    THIRD_S,
    FOURTH_S,
    FIFTH_S
  } state_t;

  state_t                          state;
  state_t                          next_state;
  csi2_word_u                      in_w;
  csi2_word_u                      dly_w;
  logic                            in_xfer;
  logic [`CSI2_GRP_W/8-1:0][7:0]   grp_q;
  logic                            grp_last_q;
  logic                            grp_valid_q;

  assign pkt_ready_o = pkt_ready_i;
  assign in_xfer     = pkt_i.valid && pkt_ready_o;
  assign in_w        = pkt_i.data;

  always_comb
  begin
    next_state = state;
    if ( in_xfer )
    begin
      if ( pkt_i.last )
        next_state = FIRST_S;  // realign at packet end.
      else
        case ( state )
          FIRST_S:  next_state = SECOND_S;
          SECOND_S: next_state = THIRD_S;
          THIRD_S:  next_state = FOURTH_S;
          FOURTH_S: next_state = FIFTH_S;
          default:  next_state = FIRST_S;
        endcase
    end
  end

  always_ff @( posedge clk_i )
    if ( srst_i )
      state <= FIRST_S;
    else
      state <= next_state;

  // previous word, its upper bytes start the next group.
  always_ff @( posedge clk_i )
    if ( in_xfer )
      dly_w <= in_w;

  always_ff @( posedge clk_i )
    if ( in_xfer )
      case ( state )
        FIRST_S:
        begin
          grp_q[3:0] <= in_w.bytes;
        end
        SECOND_S:
        begin
          grp_q[4] <= in_w.bytes[0];
        end
        THIRD_S:
        begin
          grp_q[2:0] <= dly_w.bytes[3:1];
          grp_q[4:3] <= in_w.bytes[1:0];
        end
        FOURTH_S:
        begin
          grp_q[1:0] <= dly_w.bytes[3:2];
          grp_q[4:2] <= in_w.bytes[2:0];
        end
        FIFTH_S:
        begin
          grp_q[0]   <= dly_w.bytes[3];
          grp_q[4:1] <= in_w.bytes;
        end
        default:
        begin
          grp_q <= grp_q;
        end
      endcase

  // a group completes on every beat except the first of five.
  always_ff @( posedge clk_i )
    if ( srst_i )
      grp_valid_q <= 1'b0;
    else if ( in_xfer && ( state != FIRST_S ) )
      grp_valid_q <= 1'b1;
    else if ( pkt_ready_i )
      grp_valid_q <= 1'b0;

  always_ff @( posedge clk_i )
    if ( srst_i )
      grp_last_q <= 1'b0;
    else if ( in_xfer )
      grp_last_q <= pkt_i.last;

  assign pkt_o = '{data: grp_q, last: grp_last_q, valid: grp_valid_q};

endmodule

`default_nettype wire

// ==== verilog/csi2_raw10_rx.sv ====
`timescale 1ns/1ps
`default_nettype none

module csi2_raw10_rx
(
  input  wire                            clk_i,
  input  wire                            srst_i,
  input  wire csi2_rx_pkg::stream32_t    pkt_i,
  output logic                           pkt_ready_o,
  output csi2_rx_pkg::pix_stream_t       pix_o,
  input  wire                            pix_ready_i,
  output csi2_rx_pkg::hdr_rpt_t          hdr_o,
  output logic                           len_err_o
);

  import csi2_rx_pkg::*;

  stream32_t pay_s;
  logic      pay_ready;
  stream40_t grp_s;
  logic      grp_ready;

  csi2_pkt_hdr_parser i_parser
  (
    .clk_i       ( clk_i       ),
    .srst_i      ( srst_i      ),
    .pkt_i       ( pkt_i       ),
    .pkt_ready_o ( pkt_ready_o ),
    .pay_o       ( pay_s       ),
    .pay_ready_i ( pay_ready   ),
    .hdr_o       ( hdr_o       ),
    .len_err_o   ( len_err_o   )
  );

  csi2_raw10_32b_40b_gbx i_gbx
  (
    .clk_i       ( clk_i     ),
    .srst_i      ( srst_i    ),
    .pkt_i       ( pay_s     ),
    .pkt_ready_o ( pay_ready ),
    .pkt_o       ( grp_s     ),
    .pkt_ready_i ( grp_ready )
  );

  csi2_raw10_unpacker i_unpacker
  (
    .clk_i       ( clk_i       ),
    .srst_i      ( srst_i      ),
    .grp_i       ( grp_s       ),
    .grp_ready_o ( grp_ready   ),
    .pix_o       ( pix_o       ),
    .pix_ready_i ( pix_ready_i )
  );

endmodule

`default_nettype wire

// ==== verilog/csi2_raw10_unpacker.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "csi2_rx_settings.svh"

module csi2_raw10_unpacker
(
  input  wire                            clk_i,
  input  wire                            srst_i,
  input  wire csi2_rx_pkg::stream40_t    grp_i,
  output logic                           grp_ready_o,
  output csi2_rx_pkg::pix_stream_t       pix_o,
  input  wire                            pix_ready_i
);

  import csi2_rx_pkg::*;

  logic [`CSI2_GRP_W/8-1:0][7:0] grp_b;
  pix_grp_t                      pix_d;
  logic                          grp_xfer;

  assign grp_ready_o = pix_ready_i;
  assign grp_xfer    = grp_i.valid && grp_ready_o;
  assign grp_b       = grp_i.data;

  // msbs in bytes 0..3, lsb pairs packed in byte 4.
  always_comb
  begin
    for ( int k = 0; k < `CSI2_PIX_PER_GRP; k++ )
      pix_d[k] = { grp_b[k], grp_b[`CSI2_PIX_PER_GRP][2*k+1 -: 2] };
  end

  always_ff @( posedge clk_i )
    if ( srst_i )
      pix_o.valid <= 1'b0;
    else if ( grp_xfer )
    begin
      pix_o.pix   <= pix_d;
      pix_o.last  <= grp_i.last;
      pix_o.valid <= 1'b1;
    end
    else if ( pix_ready_i )
      pix_o.valid <= 1'b0;  // drained.

endmodule

`default_nettype wire

// ==== verilog/csi2_rx_pkg.sv ====
`default_nettype none

`include "csi2_rx_settings.svh"

package csi2_rx_pkg;

  typedef struct packed {
    logic [7:0]  ecc;
    logic [15:0] wc;  // payload length in bytes.
    logic [1:0]  vc;
    logic [5:0]  dt;
  } csi2_hdr_t;

  // header beat vs payload beat.
  typedef union packed {
    csi2_hdr_t       hdr;
    logic [3:0][7:0] bytes;  // byte 0 goes first on the wire.
  } csi2_word_u;

  typedef struct packed {
    logic [`CSI2_WORD_W-1:0] data;
    logic                    last;
    logic                    valid;
  } stream32_t;

  typedef struct packed {
    logic [`CSI2_GRP_W-1:0] data;
    logic                   last;
    logic                   valid;
  } stream40_t;

  typedef logic [`CSI2_PIX_PER_GRP-1:0][`CSI2_PIX_W-1:0] pix_grp_t;

  typedef struct packed {
    pix_grp_t pix;
    logic     last;
    logic     valid;
  } pix_stream_t;

  typedef struct packed {
    logic [1:0]  vc;
    logic [5:0]  dt;
    logic [15:0] wc;
    logic        valid;
  } hdr_rpt_t;

endpackage

`default_nettype wire

// ==== verilog/csi2_rx_settings.svh ====
`ifndef CSI2_RX_SETTINGS_SVH
`define CSI2_RX_SETTINGS_SVH

// input word from the lane merger.
`define CSI2_WORD_W       32

// one RAW10 group, four pixels packed into five bytes.
`define CSI2_GRP_W        40

`define CSI2_PIX_W        10

`define CSI2_PIX_PER_GRP  4

// data type field of the packet header.
`define CSI2_DT_RAW10     6'h2B

`endif
